/* Bender.yml */
package:
  name: stage4_mem_stage

sources:
  - hw/mem_bus_pkg.sv
  - hw/rv32v_types_pkg.sv
  - hw/rv32v_mem_serializer.sv
  - hw/mem_arbiter.sv
  - hw/load_store_controller.sv
  - hw/data_ram.sv
  - hw/rv32v_write_xbar.sv
  - hw/stage4_mem_stage.sv
  - target: test
    files:
      - tb/tb_stage4_mem_stage.sv

/* hw/data_ram.sv */
// Byte-writable data RAM with fixed wait states
module data_ram #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_CYCLES = 1
) (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  mem_bus_pkg::bus_req_t bus_req,
    output mem_bus_pkg::bus_rsp_t bus_rsp
);

    localparam int AW = $clog2(MEM_WORDS);
    localparam int CW = $clog2(WAIT_CYCLES + 2);

    mem_bus_pkg::word_t mem [MEM_WORDS];
    mem_bus_pkg::word_t rdata_q;
    logic [CW-1:0]      cnt_q;
    logic [AW-1:0]      idx;
    logic               active;
    logic               ready_q;
    logic               fire;

    assign idx    = bus_req.word_addr[AW-1:0];
    assign active = bus_req.ren | bus_req.wen;
    // Counter passes WAIT_CYCLES once per request
    assign fire   = active && (cnt_q == CW'(WAIT_CYCLES));

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            cnt_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= fire;
            if (!active)
                cnt_q <= '0;
            else if (cnt_q <= CW'(WAIT_CYCLES))
                cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fire) begin
            rdata_q <= mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (bus_req.wen && bus_req.byte_en[b])
                    mem[idx][8*b +: 8] <= bus_req.wdata[8*b +: 8];
            end
        end
    end

    assign bus_rsp.ready = ready_q;
    assign bus_rsp.rdata = rdata_q;

endmodule

/* hw/load_store_controller.sv */
// Load-store controller: alignment check, bus drive with byte enables, load extension
module load_store_controller (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  mem_bus_pkg::mem_req_t req,
    input  mem_bus_pkg::bus_rsp_t bus_rsp,
    output mem_bus_pkg::bus_req_t bus_req,
    output logic                  lsc_ready,
    output logic                  mal_addr,
    output mem_bus_pkg::word_t    dload_ext
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } state_e;

    state_e                  state_q;
    logic                    start;
    logic                    misaligned;
    logic                    ren_q;
    logic                    wen_q;
    mem_bus_pkg::addr_t      addr_q;
    mem_bus_pkg::word_t      wdata_q;
    mem_bus_pkg::byte_en_t   be;
    mem_bus_pkg::byte_en_t   be_q;
    mem_bus_pkg::load_type_e type_q;
    logic [1:0]              off_q;
    mem_bus_pkg::word_t      load_shift;

    assign start = req.dren | req.dwen;

    // Alignment and byte lanes from access size
    always_comb begin
        case (req.load_type)
            mem_bus_pkg::LH, mem_bus_pkg::LHU: begin
                misaligned = req.addr[0];
                be         = 4'b0011 << req.addr[1:0];
            end
            mem_bus_pkg::LW: begin
                misaligned = (req.addr[1:0] != 2'b00);
                be         = 4'b1111;
            end
            default: begin
                misaligned = 1'b0;
                be         = 4'b0001 << req.addr[1:0];
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state_q <= IDLE;
            ren_q   <= 1'b0;
            wen_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start && misaligned) begin
                        state_q <= DONE;
                    end else if (start) begin
                        state_q <= ACCESS;
                        ren_q   <= req.dren;
                        wen_q   <= req.dwen;
                    end
                end
                ACCESS: begin
                    if (bus_rsp.ready) begin
                        state_q <= IDLE;
                        ren_q   <= 1'b0;
                        wen_q   <= 1'b0;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state_q == IDLE && start) begin
            addr_q  <= {2'b00, req.addr[31:2]};
            wdata_q <= req.store_data << {req.addr[1:0], 3'b000};
            be_q    <= be;
            type_q  <= req.load_type;
            off_q   <= req.addr[1:0];
        end
    end

    assign bus_req.ren       = ren_q;
    assign bus_req.wen       = wen_q;
    assign bus_req.word_addr = addr_q;
    assign bus_req.wdata     = wdata_q;
    assign bus_req.byte_en   = be_q;

    // Misaligned accesses finish in DONE without touching the bus
    assign lsc_ready = (state_q == ACCESS && bus_rsp.ready) || (state_q == DONE);
    assign mal_addr  = (state_q == DONE);

    assign load_shift = bus_rsp.rdata >> {off_q, 3'b000};

    always_comb begin
        case (type_q)
            mem_bus_pkg::LB:  dload_ext = {{24{load_shift[7]}}, load_shift[7:0]};
            mem_bus_pkg::LBU: dload_ext = {24'b0, load_shift[7:0]};
            mem_bus_pkg::LH:  dload_ext = {{16{load_shift[15]}}, load_shift[15:0]};
            mem_bus_pkg::LHU: dload_ext = {16'b0, load_shift[15:0]};
            default:          dload_ext = load_shift;
        endcase
    end

endmodule

/* hw/mem_arbiter.sv */
// Scalar and vector arbiter in front of the load-store controller
module mem_arbiter (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  mem_bus_pkg::mem_req_t scalar_req,
    input  mem_bus_pkg::mem_req_t vector_req,
    input  logic                  suppress,
    input  logic                  lsc_ready,
    output mem_bus_pkg::mem_req_t lsc_req,
    output logic                  scalar_ready,
    output logic                  vector_ready,
    output logic                  busy
);

    typedef enum logic [1:0] {
        NONE,
        SCALAR,
        VECTOR
    } grant_e;

    grant_e grant_q;
    grant_e owner;
    logic   scalar_valid;
    logic   vector_valid;
    logic   issued_q;
    logic   done;

    assign scalar_valid = scalar_req.dren | scalar_req.dwen;
    assign vector_valid = vector_req.dren | vector_req.dwen;
    assign busy         = scalar_valid | vector_valid;

    // Vector wins unless a scalar access already owns the controller
    always_comb begin
        owner = grant_q;
        if (grant_q == NONE) begin
            if (vector_valid)
                owner = VECTOR;
            else if (scalar_valid)
                owner = SCALAR;
        end
    end

    always_comb begin
        lsc_req      = (owner == VECTOR) ? vector_req : scalar_req;
        lsc_req.dren = lsc_req.dren & ~suppress;
        lsc_req.dwen = lsc_req.dwen & ~suppress;
    end

    // A suppressed access that never reached the controller completes here
    assign done = lsc_ready | (suppress & ~issued_q & (owner != NONE));

    assign scalar_ready = done & (owner == SCALAR);
    assign vector_ready = done & (owner == VECTOR);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            grant_q  <= NONE;
            issued_q <= 1'b0;
        end else if (done) begin
            grant_q  <= NONE;
            issued_q <= 1'b0;
        end else begin
            grant_q <= owner;
            if (lsc_req.dren | lsc_req.dwen)
                issued_q <= 1'b1;
        end
    end

endmodule

/* hw/mem_bus_pkg.sv */
// Scalar bus types: word, address, byte enable, load type enum, request and response structs
package mem_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_en_t;

    // Stores reuse LB, LH and LW to give their size
    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU
    } load_type_e;

    // Request from a requester to the load-store controller
    typedef struct packed {
        logic       dren;
        logic       dwen;
        addr_t      addr;
        word_t      store_data;
        load_type_e load_type;
    } mem_req_t;

    // RAM side, word addressed
    typedef struct packed {
        logic     ren;
        logic     wen;
        addr_t    word_addr;
        word_t    wdata;
        byte_en_t byte_en;
    } bus_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;
    } bus_rsp_t;

endpackage

/* hw/rv32v_mem_serializer.sv */
// Vector memory serializer: one scalar-sized access per lane, lanes in order
module rv32v_mem_serializer (
    input  logic                        CLK,
    input  logic                        rst_n,
    input  rv32v_types_pkg::vmem_req_t  vec_req,
    input  logic                        lane_ready,
    output mem_bus_pkg::mem_req_t       lane_req,
    output rv32v_types_pkg::lane_idx_t  curr_lane,
    output logic                        lane_done,
    output logic                        vec_done
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        LAST
    } state_e;

    state_e                     state_q;
    rv32v_types_pkg::lane_idx_t lane_q;
    logic [2:0]                 esize;
    mem_bus_pkg::load_type_e    ltype;

    // Element size in bytes and access type
    always_comb begin
        case (vec_req.eew)
            rv32v_types_pkg::EEW8: begin
                esize = 3'd1;
                ltype = mem_bus_pkg::LB;
            end
            rv32v_types_pkg::EEW16: begin
                esize = 3'd2;
                ltype = mem_bus_pkg::LH;
            end
            default: begin
                esize = 3'd4;
                ltype = mem_bus_pkg::LW;
            end
        endcase
    end

    // Lane 0 goes out straight from idle
    assign lane_req.dren       = vec_req.vmemdren;
    assign lane_req.dwen       = vec_req.vmemdwen;
    assign lane_req.addr       = vec_req.addr +
                                 mem_bus_pkg::addr_t'(lane_q) * mem_bus_pkg::addr_t'(esize);
    assign lane_req.store_data = vec_req.store_data[lane_q];
    assign lane_req.load_type  = ltype;

    assign curr_lane = lane_q;
    assign lane_done = lane_ready & vec_req.vmemdren;
    assign vec_done  = lane_ready & (state_q == LAST);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state_q <= IDLE;
            lane_q  <= '0;
        end else if (lane_ready) begin
            case (state_q)
                IDLE: begin
                    lane_q  <= lane_q + 1'b1;
                    state_q <= ISSUE;
                end
                ISSUE: begin
                    lane_q <= lane_q + 1'b1;
                    // Next lane is the final one
                    if (lane_q == rv32v_types_pkg::lane_idx_t'(rv32v_types_pkg::NUM_LANES - 2))
                        state_q <= LAST;
                end
                default: begin
                    lane_q  <= '0;
                    state_q <= IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/rv32v_types_pkg.sv */
// Vector types: lane count, lane index, element width enum, vector request and write-back structs
package rv32v_types_pkg;

    localparam int NUM_LANES = 4;

    typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;
    typedef logic [31:0] lane_data_t;

    typedef enum logic [1:0] {
        EEW8,
        EEW16,
        EEW32
    } eew_e;

    // Unit-stride vector memory request from execute
    typedef struct packed {
        logic                              vmemdren;
        logic                              vmemdwen;
        mem_bus_pkg::addr_t                addr;
        eew_e                              eew;
        logic [1:0]                        bank_offset;
        lane_data_t [NUM_LANES-1:0]        store_data;
    } vmem_req_t;

    // Write port of one vector register bank
    typedef struct packed {
        lane_data_t            vwdata;
        mem_bus_pkg::byte_en_t vbyte_wen;
    } vwb_t;

endpackage

/* hw/rv32v_write_xbar.sv */
// Write-back crossbar for one vector register bank
module rv32v_write_xbar #(
    parameter int BANK_NUM = 0
) (
    input  rv32v_types_pkg::lane_data_t [rv32v_types_pkg::NUM_LANES-1:0] lane_data,
    input  logic [rv32v_types_pkg::NUM_LANES-1:0]                        lane_wen,
    input  rv32v_types_pkg::eew_e                                        eew,
    input  logic [1:0]                                                   bank_offset,
    output mem_bus_pkg::word_t                                           vwdata,
    output mem_bus_pkg::byte_en_t                                        byte_wen
);

    logic [2:0]            esize;
    mem_bus_pkg::word_t    elem_mask;
    mem_bus_pkg::byte_en_t elem_be;
    logic [3:0]            pos [rv32v_types_pkg::NUM_LANES];

    always_comb begin
        case (eew)
            rv32v_types_pkg::EEW8: begin
                esize     = 3'd1;
                elem_mask = 32'h0000_00ff;
                elem_be   = 4'b0001;
            end
            rv32v_types_pkg::EEW16: begin
                esize     = 3'd2;
                elem_mask = 32'h0000_ffff;
                elem_be   = 4'b0011;
            end
            default: begin
                esize     = 3'd4;
                elem_mask = 32'hffff_ffff;
                elem_be   = 4'b1111;
            end
        endcase
    end

    // Byte position in the 16-byte row, wraps modulo 16
    always_comb begin
        vwdata   = '0;
        byte_wen = '0;
        for (int i = 0; i < rv32v_types_pkg::NUM_LANES; i++) begin
            pos[i] = 4'({bank_offset, 2'b00} + i * esize);
            // Elements are size aligned so none straddles two banks
            if (lane_wen[i] && pos[i][3:2] == 2'(BANK_NUM)) begin
                vwdata   = vwdata | ((lane_data[i] & elem_mask) << {pos[i][1:0], 3'b000});
                byte_wen = byte_wen | (elem_be << pos[i][1:0]);
            end
        end
    end

endmodule

/* hw/stage4_mem_stage.sv */
// Memory stage top: serializer, arbiter, load-store controller, data RAM and bank crossbars
module stage4_mem_stage #(
    parameter int MEM_WORDS   = 256,
    parameter int WAIT_CYCLES = 1
) (
    input  logic                                                   CLK,
    input  logic                                                   rst_n,
    input  mem_bus_pkg::mem_req_t                                  scalar_req,
    input  rv32v_types_pkg::vmem_req_t                             vec_req,
    input  logic                                                   suppress,
    output logic                                                   busy,
    output logic                                                   scalar_done,
    output logic                                                   vec_done,
    output logic                                                   mal,
    output mem_bus_pkg::word_t                                     load_data,
    output rv32v_types_pkg::vwb_t [rv32v_types_pkg::NUM_LANES-1:0] vwb
);

    mem_bus_pkg::mem_req_t      lane_req;
    mem_bus_pkg::mem_req_t      lsc_req;
    mem_bus_pkg::bus_req_t      bus_req;
    mem_bus_pkg::bus_rsp_t      bus_rsp;
    rv32v_types_pkg::lane_idx_t curr_lane;
    logic                       lane_ready;
    logic                       lane_done;
    logic                       lsc_ready;

    rv32v_types_pkg::lane_data_t [rv32v_types_pkg::NUM_LANES-1:0] lane_data;
    logic [rv32v_types_pkg::NUM_LANES-1:0]                        lane_wen;

    rv32v_mem_serializer u_serializer (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .vec_req    (vec_req),
        .lane_ready (lane_ready),
        .lane_req   (lane_req),
        .curr_lane  (curr_lane),
        .lane_done  (lane_done),
        .vec_done   (vec_done)
    );

    mem_arbiter u_arbiter (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .scalar_req   (scalar_req),
        .vector_req   (lane_req),
        .suppress     (suppress),
        .lsc_ready    (lsc_ready),
        .lsc_req      (lsc_req),
        .scalar_ready (scalar_done),
        .vector_ready (lane_ready),
        .busy         (busy)
    );

    load_store_controller u_lsc (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .req       (lsc_req),
        .bus_rsp   (bus_rsp),
        .bus_req   (bus_req),
        .lsc_ready (lsc_ready),
        .mal_addr  (mal),
        .dload_ext (load_data)
    );

    data_ram #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) u_ram (
        .CLK     (CLK),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    // Every lane sees the load word, only the current lane writes
    assign lane_data = {rv32v_types_pkg::NUM_LANES{load_data}};

    always_comb begin
        lane_wen = '0;
        if (lane_done && !mal && !suppress)
            lane_wen[curr_lane] = 1'b1;
    end

    for (genvar i = 0; i < rv32v_types_pkg::NUM_LANES; i++) begin : gen_wb_xbar
        rv32v_write_xbar #(
            .BANK_NUM (i)
        ) u_xbar (
            .lane_data   (lane_data),
            .lane_wen    (lane_wen),
            .eew         (vec_req.eew),
            .bank_offset (vec_req.bank_offset),
            .vwdata      (vwb[i].vwdata),
            .byte_wen    (vwb[i].vbyte_wen)
        );
    end

endmodule

/* project.f */
hw/mem_bus_pkg.sv
hw/rv32v_types_pkg.sv
hw/rv32v_mem_serializer.sv
hw/mem_arbiter.sv
hw/load_store_controller.sv
hw/data_ram.sv
hw/rv32v_write_xbar.sv
hw/stage4_mem_stage.sv
tb/tb_stage4_mem_stage.sv

/* tb/tb_stage4_mem_stage.sv */
// Testbench for the memory stage: random scalar and vector traffic against a byte memory model
module tb_stage4_mem_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS    = 256;
    localparam int WAIT_CYCLES  = 1;
    localparam int LANES        = rv32v_types_pkg::NUM_LANES;
    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 16;
    localparam int WINDOW       = 64;
    localparam int NUM_SCALAR   = 20;
    localparam int NUM_VECTOR   = 16;
    localparam int NUM_CONC     = 4;
    localparam int OP_CYCLES    = LANES * (WAIT_CYCLES + 2) + 4;
    localparam int NUM_OPS      = WINDOW / 4 + NUM_SCALAR * 6 + 8 + NUM_VECTOR * 2 + NUM_CONC * 2;
    localparam int MARGIN_NS    = (RESET_CYCLES + 100) * CLK_NS;

    typedef rv32v_types_pkg::lane_data_t [LANES-1:0] lane_row_t;

    logic                              CLK;
    logic                              rst_n;
    mem_bus_pkg::mem_req_t             scalar_req;
    rv32v_types_pkg::vmem_req_t        vec_req;
    logic                              suppress;
    logic                              busy;
    logic                              scalar_done;
    logic                              vec_done;
    logic                              mal;
    mem_bus_pkg::word_t                load_data;
    rv32v_types_pkg::vwb_t [LANES-1:0] vwb;

    logic [15:0] lfsr_state;
    logic [7:0]  mem_model [WINDOW];
    int          mismatch_count;
    int          error_count;

    stage4_mem_stage #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_CYCLES (WAIT_CYCLES)
    ) dut_i (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .scalar_req  (scalar_req),
        .vec_req     (vec_req),
        .suppress    (suppress),
        .busy        (busy),
        .scalar_done (scalar_done),
        .vec_done    (vec_done),
        .mal         (mal),
        .load_data   (load_data),
        .vwb         (vwb)
    );

    always #(CLK_NS / 2) CLK = ~CLK;

    // 16-bit Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [1:0] rand_eew();
        logic [1:0] v;
        v = 2'(rand_bits(2));
        return (v == 2'd3) ? 2'd2 : v;
    endfunction

    function automatic int size_of(input mem_bus_pkg::load_type_e lt);
        case (lt)
            mem_bus_pkg::LH, mem_bus_pkg::LHU: return 2;
            mem_bus_pkg::LW: return 4;
            default: return 1;
        endcase
    endfunction

    function automatic logic misaligned(input mem_bus_pkg::load_type_e lt, input logic [31:0] addr);
        return (int'(addr[1:0]) % size_of(lt)) != 0;
    endfunction

    function automatic logic [31:0] model_load(input mem_bus_pkg::load_type_e lt,
                                               input logic [31:0] addr);
        logic [31:0] raw;
        raw = '0;
        for (int k = 0; k < size_of(lt); k++)
            raw[8*k +: 8] = mem_model[(int'(addr) + k) % WINDOW];
        case (lt)
            mem_bus_pkg::LB: return {{24{raw[7]}}, raw[7:0]};
            mem_bus_pkg::LH: return {{16{raw[15]}}, raw[15:0]};
            default:         return raw;
        endcase
    endfunction

    function automatic void model_store(input mem_bus_pkg::load_type_e lt,
                                        input logic [31:0] addr, input logic [31:0] data);
        for (int k = 0; k < size_of(lt); k++)
            mem_model[(int'(addr) + k) % WINDOW] = data[8*k +: 8];
    endfunction

    function automatic logic [31:0] elem_mask(input int esz);
        return (esz == 4) ? 32'hffff_ffff : ((32'd1 << (8 * esz)) - 32'd1);
    endfunction

    // Each byte carries its own address, scrambled
    function automatic logic [31:0] fill_word(input int a);
        return {8'(a + 3), 8'(a + 2), 8'(a + 1), 8'(a)} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic any_vbyte_wen();
        logic found;
        found = 1'b0;
        for (int b = 0; b < LANES; b++)
            found = found | (|vwb[b].vbyte_wen);
        return found;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_count++;
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_cond(input logic ok, input string what);
        assert (ok === 1'b1) else begin
            error_count++;
            $display("Error: %s at %0t", what, $time);
        end
    endtask

    task automatic release_scalar();
        @(posedge CLK);
        scalar_req <= '0;
        suppress   <= 1'b0;
        @(negedge CLK);
        check_equal("scalar_done", scalar_done, 1'b0);
        check_equal("busy", busy, 1'b0);
    endtask

    task automatic scalar_op(input logic is_store, input mem_bus_pkg::load_type_e lt,
                             input logic [31:0] addr, input logic [31:0] data, input logic sup);
        mem_bus_pkg::mem_req_t req;
        logic                  exp_mal;
        logic [31:0]           exp_data;
        logic                  seen;
        int                    n;
        exp_mal        = misaligned(lt, addr);
        exp_data       = model_load(lt, addr);
        req.dren       = ~is_store;
        req.dwen       = is_store;
        req.addr       = addr;
        req.store_data = data;
        req.load_type  = lt;
        @(posedge CLK);
        scalar_req <= req;
        suppress   <= sup;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 2 * OP_CYCLES) begin
            @(negedge CLK);
            seen = scalar_done;
            if (!seen)
                n++;
            check_cond(!any_vbyte_wen(), "vector byte enable set during a scalar access");
        end
        check_cond(seen, "scalar request got no done pulse");
        // Suppressed requests leave memory as it was
        if (!sup) begin
            check_equal("scalar_done latency", n, exp_mal ? 1 : WAIT_CYCLES + 2);
            check_equal("mal", mal, exp_mal);
            if (!exp_mal && !is_store)
                check_equal("load_data", load_data, exp_data);
            if (!exp_mal && is_store)
                model_store(lt, addr, data);
        end
        release_scalar();
    endtask

    task automatic vector_op(input logic is_load, input logic [31:0] base,
                             input logic [1:0] eew_val, input logic [1:0] bo,
                             input lane_row_t sdata);
        rv32v_types_pkg::vmem_req_t req;
        mem_bus_pkg::load_type_e    lt;
        logic                       mis [LANES];
        int                         bank [LANES];
        logic [31:0]                wd [LANES];
        logic [3:0]                 be [LANES];
        int                         esz;
        int                         p;
        int                         nxt;
        int                         mal_seen;
        int                         mal_exp;
        int                         n;
        logic                       seen;
        esz     = 1 << eew_val;
        lt      = (esz == 1) ? mem_bus_pkg::LB : (esz == 2) ? mem_bus_pkg::LH : mem_bus_pkg::LW;
        mal_exp = 0;
        for (int i = 0; i < LANES; i++) begin
            mis[i] = misaligned(lt, base + i * esz);
            if (mis[i])
                mal_exp++;
            // Element i starts at byte 4*bank_offset + i*E of a 16-byte row
            p       = (4 * bo + i * esz) % 16;
            bank[i] = p / 4;
            be[i]   = 4'(((1 << esz) - 1) << (p % 4));
            wd[i]   = (model_load(lt, base + i * esz) & elem_mask(esz)) << (8 * (p % 4));
        end
        req.vmemdren    = is_load;
        req.vmemdwen    = ~is_load;
        req.addr        = base;
        req.eew         = rv32v_types_pkg::eew_e'(eew_val);
        req.bank_offset = bo;
        req.store_data  = sdata;
        @(posedge CLK);
        vec_req <= req;
        nxt      = 0;
        mal_seen = 0;
        n        = 0;
        seen     = 1'b0;
        while (!seen && n < 2 * LANES * OP_CYCLES) begin
            @(negedge CLK);
            n++;
            seen = vec_done;
            if (mal)
                mal_seen++;
            if (any_vbyte_wen()) begin
                while (nxt < LANES && mis[nxt])
                    nxt++;
                if (!is_load || nxt == LANES) begin
                    check_cond(1'b0, "unexpected vector write-back");
                end else begin
                    for (int b = 0; b < LANES; b++) begin
                        check_equal($sformatf("vwb[%0d].vwdata", b), vwb[b].vwdata,
                                    (b == bank[nxt]) ? wd[nxt] : 32'h0);
                        check_equal($sformatf("vwb[%0d].vbyte_wen", b), vwb[b].vbyte_wen,
                                    (b == bank[nxt]) ? be[nxt] : 4'h0);
                    end
                    nxt++;
                end
            end
        end
        while (nxt < LANES && mis[nxt])
            nxt++;
        check_cond(seen, "vector request got no vec_done pulse");
        check_equal("vector mal pulses", mal_seen, mal_exp);
        if (is_load)
            check_equal("vector lane write-backs", nxt, LANES);
        for (int i = 0; i < LANES; i++) begin
            if (!is_load && !mis[i])
                model_store(lt, base + i * esz, sdata[i]);
        end
        @(posedge CLK);
        vec_req <= '0;
        @(negedge CLK);
        check_equal("vec_done", vec_done, 1'b0);
        check_equal("busy", busy, 1'b0);
    endtask

    // Vector store and scalar load presented in the same cycle
    task automatic concurrent_op(input logic [31:0] base, input logic [1:0] eew_val,
                                 input logic [1:0] bo, input lane_row_t sdata,
                                 input logic [31:0] saddr);
        rv32v_types_pkg::vmem_req_t vreq;
        mem_bus_pkg::mem_req_t      sreq;
        mem_bus_pkg::load_type_e    lt;
        logic [31:0]                exp_data;
        logic                       vec_seen;
        logic                       sc_seen;
        int                         esz;
        int                         n;
        esz = 1 << eew_val;
        lt  = (esz == 1) ? mem_bus_pkg::LB : (esz == 2) ? mem_bus_pkg::LH : mem_bus_pkg::LW;
        for (int i = 0; i < LANES; i++)
            model_store(lt, base + i * esz, sdata[i]);
        exp_data         = model_load(mem_bus_pkg::LW, saddr);
        vreq.vmemdren    = 1'b0;
        vreq.vmemdwen    = 1'b1;
        vreq.addr        = base;
        vreq.eew         = rv32v_types_pkg::eew_e'(eew_val);
        vreq.bank_offset = bo;
        vreq.store_data  = sdata;
        sreq.dren        = 1'b1;
        sreq.dwen        = 1'b0;
        sreq.addr        = saddr;
        sreq.store_data  = '0;
        sreq.load_type   = mem_bus_pkg::LW;
        @(posedge CLK);
        vec_req    <= vreq;
        scalar_req <= sreq;
        vec_seen = 1'b0;
        sc_seen  = 1'b0;
        n        = 0;
        while (!sc_seen && n < 4 * LANES * OP_CYCLES) begin
            @(negedge CLK);
            n++;
            check_equal("busy", busy, 1'b1);
            check_cond(!any_vbyte_wen(), "vector byte enable set during a vector store");
            if (scalar_done) begin
                sc_seen = 1'b1;
                check_cond(vec_seen, "scalar request completed before the vector request");
                check_equal("load_data", load_data, exp_data);
            end
            if (vec_done) begin
                vec_seen = 1'b1;
                @(posedge CLK);
                vec_req <= '0;
            end
        end
        check_cond(sc_seen, "scalar request got no done pulse after the vector request");
        release_scalar();
    endtask

    initial begin
        #(NUM_OPS * OP_CYCLES * CLK_NS + MARGIN_NS);
        $display("Error: watchdog expired at %0t, the DUT stopped responding", $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0]             addr;
        logic [31:0]             data;
        mem_bus_pkg::load_type_e lt;
        logic [1:0]              eew_val;
        logic [1:0]              bo;
        lane_row_t               row;
        CLK            = 1'b0;
        rst_n          = 1'b0;
        scalar_req     = '0;
        vec_req        = '0;
        suppress       = 1'b0;
        lfsr_state     = 16'd95;
        mismatch_count = 0;
        error_count    = 0;
        repeat (RESET_CYCLES) @(posedge CLK);
        rst_n <= 1'b1;

        // Quiet outputs before any request
        repeat (3) begin
            @(negedge CLK);
            check_equal("busy", busy, 1'b0);
            check_equal("scalar_done", scalar_done, 1'b0);
            check_equal("vec_done", vec_done, 1'b0);
            check_equal("mal", mal, 1'b0);
            check_cond(!any_vbyte_wen(), "vector byte enable set after reset");
        end

        for (int a = 0; a < WINDOW; a += 4)
            scalar_op(1'b1, mem_bus_pkg::LW, a, fill_word(a), 1'b0);

        for (int it = 0; it < NUM_SCALAR; it++) begin
            addr = rand_bits(6);
            data = rand_bits(32);
            lt   = mem_bus_pkg::load_type_e'(rand_bits(2) % 3);
            scalar_op(1'b1, lt, addr, data, 1'b0);
            // Read back with every load type
            for (int k = 0; k < 5; k++)
                scalar_op(1'b0, mem_bus_pkg::load_type_e'(k), addr, 32'h0, 1'b0);
        end

        // Misaligned accesses then aligned reads of the same words
        scalar_op(1'b1, mem_bus_pkg::LH, 32'd33, 32'hdead_beef, 1'b0);
        scalar_op(1'b1, mem_bus_pkg::LW, 32'd38, 32'hcafe_f00d, 1'b0);
        scalar_op(1'b0, mem_bus_pkg::LHU, 32'd41, 32'h0, 1'b0);
        scalar_op(1'b0, mem_bus_pkg::LW, 32'd32, 32'h0, 1'b0);
        scalar_op(1'b0, mem_bus_pkg::LW, 32'd36, 32'h0, 1'b0);

        addr = rand_bits(4) << 2;
        scalar_op(1'b1, mem_bus_pkg::LW, addr, rand_bits(32), 1'b1);
        scalar_op(1'b0, mem_bus_pkg::LW, addr, 32'h0, 1'b0);

        for (int it = 0; it < NUM_VECTOR; it++) begin
            addr = rand_bits(5);
            for (int i = 0; i < LANES; i++)
                row[i] = rand_bits(32);
            eew_val = rand_eew();
            bo      = 2'(rand_bits(2));
            vector_op(1'b0, addr, eew_val, bo, row);
            eew_val = rand_eew();
            bo      = 2'(rand_bits(2));
            vector_op(1'b1, addr, eew_val, bo, row);
        end

        for (int it = 0; it < NUM_CONC; it++) begin
            addr = rand_bits(3) << 2;
            for (int i = 0; i < LANES; i++)
                row[i] = rand_bits(32);
            eew_val = rand_eew();
            bo      = 2'(rand_bits(2));
            data    = addr + (rand_bits(2) << 2);
            concurrent_op(addr, eew_val, bo, row, data);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
